//--- Bender.yml
package:
  name: core_top

sources:
  - source/core_pkg.sv
  - source/alu.sv
  - source/regfile.sv
  - source/instr_decode.sv
  - source/pipeline_ctrl.sv
  - source/dcache.sv
  - source/core_top.sv
  - target: test
    files:
      - test/core_assertions.sv
      - test/tb_core_top.sv

//--- list.f
source/core_pkg.sv
source/alu.sv
source/regfile.sv
source/instr_decode.sv
source/pipeline_ctrl.sv
source/dcache.sv
source/core_top.sv
test/core_assertions.sv
test/tb_core_top.sv

//--- source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import core_pkg::*; (
	input  alu_op_t           alu_op,
	input  logic [DATA_W-1:0] src1,
	input  logic [DATA_W-1:0] src2,
	output logic [DATA_W-1:0] result,
	output logic              overflow
);

	localparam int MSB = DATA_W - 1;

	always_comb begin
		result = '0;
		overflow = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				result = src1 + src2;
				// same signs in, other sign out
				overflow = (src1[MSB] == src2[MSB]) && (result[MSB] != src1[MSB]);
			end
			ALU_SUB: begin
				result = src1 - src2;
				overflow = (src1[MSB] != src2[MSB]) && (result[MSB] != src1[MSB]);
			end
			ALU_AND: result = src1 & src2;
			ALU_OR:  result = src1 | src2;
			ALU_XOR: result = src1 ^ src2;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 5;

	// major opcodes, instruction bits 30:25
	localparam logic [5:0] OP_ALU  = 6'b100000;
	localparam logic [5:0] OP_ADDI = 6'b101000;
	localparam logic [5:0] OP_ORI  = 6'b101100;
	localparam logic [5:0] OP_LWI  = 6'b000010;
	localparam logic [5:0] OP_SWI  = 6'b001010;
	localparam logic [5:0] OP_BEQ  = 6'b100110;

	// register form sub-opcodes, bits 4:0
	localparam logic [4:0] SUB_ADD = 5'b00000;
	localparam logic [4:0] SUB_SUB = 5'b00001;
	localparam logic [4:0] SUB_AND = 5'b00010;
	localparam logic [4:0] SUB_XOR = 5'b00011;
	localparam logic [4:0] SUB_OR  = 5'b00100;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_t;

	typedef struct packed {
		logic       unused;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] spare;
		logic [4:0] sub_op;
	} instr_reg_t;

	typedef struct packed {
		logic        unused;
		logic [5:0]  opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [14:0] imm;
	} instr_imm_t;

	// one instruction word, read as register form or immediate form
	typedef union packed {
		instr_reg_t rtype;
		instr_imm_t itype;
	} instr_u;

endpackage

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; #(
	parameter int CACHE_LINES = 16
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        run,

	output logic [9:0]  im_address,
	input  logic [31:0] instruction,

	output logic        alu_overflow,

	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output logic [29:0] wb_adr,
	output logic [31:0] wb_dat_write,
	input  logic [31:0] wb_dat_read,
	input  logic        wb_ack
);

	// pipeline to cache
	logic              mem_strobe;
	logic              mem_write;
	logic [DATA_W-1:0] mem_address;
	logic [DATA_W-1:0] mem_write_data;
	logic [DATA_W-1:0] mem_read_data;
	logic              cache_ready;

	pipeline_ctrl pipe (
		.clk(clk),
		.reset(reset),
		.run(run),
		.im_address(im_address),
		.instruction(instruction),
		.alu_overflow(alu_overflow),
		.mem_strobe(mem_strobe),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_write_data(mem_write_data),
		.mem_read_data(mem_read_data),
		.cache_ready(cache_ready)
	);

	dcache #(
		.CACHE_LINES(CACHE_LINES)
	) dcache (
		.clk(clk),
		.reset(reset),
		.cache_ready(cache_ready),
		.mem_strobe(mem_strobe),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_write_data(mem_write_data),
		.mem_read_data(mem_read_data),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_write(wb_dat_write),
		.wb_dat_read(wb_dat_read),
		.wb_ack(wb_ack)
	);

endmodule

`default_nettype wire

//--- source/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache import core_pkg::*; #(
	parameter int CACHE_LINES = 16
) (
	input  logic              clk,
	input  logic              reset,
	output logic              cache_ready,
	input  logic              mem_strobe,
	input  logic              mem_write,
	input  logic [DATA_W-1:0] mem_address,
	input  logic [DATA_W-1:0] mem_write_data,
	output logic [DATA_W-1:0] mem_read_data,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output logic [DATA_W-3:0] wb_adr,
	output logic [DATA_W-1:0] wb_dat_write,
	input  logic [DATA_W-1:0] wb_dat_read,
	input  logic              wb_ack
);

	localparam int IDX_W = $clog2(CACHE_LINES);
	localparam int TAG_W = DATA_W - 2 - IDX_W;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_BUS  = 2'd1;
	localparam logic [1:0] S_DONE = 2'd2;

	logic [TAG_W-1:0]  tag_array  [CACHE_LINES];
	logic [DATA_W-1:0] data_array [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_bits;

	logic [1:0]       state;
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic             hit;
	logic             need_bus;

	logic              fill_en;
	logic [IDX_W-1:0]  fill_idx;
	logic [TAG_W-1:0]  fill_tag;
	logic [DATA_W-1:0] fill_data;

	// one-word lines, byte offset ignored
	assign idx = mem_address[IDX_W+1:2];
	assign tag = mem_address[DATA_W-1:IDX_W+2];

	assign hit = valid_bits[idx] && (tag_array[idx] == tag);
	assign need_bus = mem_strobe && (mem_write || !hit);

	// ready in the request cycle on a hit, or in the cycle after ack
	assign cache_ready = (state == S_IDLE && !need_bus) || (state == S_DONE);
	assign mem_read_data = data_array[idx];

	// store allocates at accept, load miss fills at ack
	always_comb begin
		fill_en = 1'b0;
		fill_idx = idx;
		fill_tag = tag;
		fill_data = mem_write_data;
		if (state == S_IDLE && need_bus && mem_write) begin
			fill_en = 1'b1;
		end else if (state == S_BUS && wb_ack && !wb_we) begin
			fill_en = 1'b1;
			fill_idx = wb_adr[IDX_W-1:0];
			fill_tag = wb_adr[DATA_W-3:IDX_W];
			fill_data = wb_dat_read;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_array[fill_idx] <= fill_tag;
			data_array[fill_idx] <= fill_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			valid_bits <= '0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			if (fill_en)
				valid_bits[fill_idx] <= 1'b1;
			case (state)
				S_IDLE: begin
					if (need_bus) begin
						state <= S_BUS;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= mem_write;
						wb_adr <= mem_address[DATA_W-1:2];
						wb_dat_write <= mem_write_data;
					end
				end
				S_BUS: begin
					if (wb_ack) begin
						state <= S_DONE;
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
					end
				end
				S_DONE: begin
					// strobe here means the pipeline takes the result
					if (mem_strobe)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode import core_pkg::*; (
	input  instr_u                  instruction,
	output alu_op_t                 alu_op,
	output logic                    use_imm,
	output logic [DATA_W-1:0]       imm_value,
	output logic                    reg_write,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic                    is_branch,
	output logic [REG_ADDR_W-1:0]   rt,
	output logic [REG_ADDR_W-1:0]   ra,
	output logic [REG_ADDR_W-1:0]   rb
);

	logic [DATA_W-1:0] imm_sext;
	logic [DATA_W-1:0] imm_zext;

	assign imm_sext = {{(DATA_W-15){instruction.itype.imm[14]}}, instruction.itype.imm};
	assign imm_zext = {{(DATA_W-15){1'b0}}, instruction.itype.imm};

	assign rt = instruction.itype.rt;
	assign ra = instruction.itype.ra;

	always_comb begin
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		imm_value = imm_sext;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		rb = instruction.rtype.rb;
		case (instruction.rtype.opcode)
			OP_ALU: begin
				reg_write = 1'b1;
				case (instruction.rtype.sub_op)
					SUB_ADD: alu_op = ALU_ADD;
					SUB_SUB: alu_op = ALU_SUB;
					SUB_AND: alu_op = ALU_AND;
					SUB_OR:  alu_op = ALU_OR;
					SUB_XOR: alu_op = ALU_XOR;
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			OP_ORI: begin
				alu_op = ALU_OR;
				use_imm = 1'b1;
				imm_value = imm_zext;
				reg_write = 1'b1;
			end
			OP_LWI: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
			end
			// store data and branch compare both need rt on the second port
			OP_SWI: begin
				use_imm = 1'b1;
				mem_write = 1'b1;
				rb = instruction.itype.rt;
			end
			OP_BEQ: begin
				is_branch = 1'b1;
				rb = instruction.itype.rt;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- source/pipeline_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline_ctrl import core_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              run,
	output logic [9:0]        im_address,
	input  logic [DATA_W-1:0] instruction,
	output logic              alu_overflow,
	output logic              mem_strobe,
	output logic              mem_write,
	output logic [DATA_W-1:0] mem_address,
	output logic [DATA_W-1:0] mem_write_data,
	input  logic [DATA_W-1:0] mem_read_data,
	input  logic              cache_ready
);

	logic advance;

	// fetch
	logic [9:0] pc;
	logic [9:0] if_pc;
	instr_u     if_instr;
	logic       if_valid;

	// execute
	alu_op_t               dec_alu_op;
	logic                  dec_use_imm;
	logic [DATA_W-1:0]     dec_imm;
	logic                  dec_reg_write;
	logic                  dec_mem_read;
	logic                  dec_mem_write;
	logic                  dec_is_branch;
	logic [REG_ADDR_W-1:0] dec_rt;
	logic [REG_ADDR_W-1:0] dec_ra;
	logic [REG_ADDR_W-1:0] dec_rb;
	logic [DATA_W-1:0]     rf_ra_data;
	logic [DATA_W-1:0]     rf_rb_data;
	logic [DATA_W-1:0]     op_a;
	logic [DATA_W-1:0]     op_b;
	logic [DATA_W-1:0]     alu_src2;
	logic [DATA_W-1:0]     alu_result;
	logic                  alu_ovf;
	logic                  arith_op;
	logic                  branch_taken;
	logic [9:0]            branch_target;

	// memory and writeback
	logic                  m_valid;
	logic                  m_reg_write;
	logic                  m_load;
	logic                  m_store;
	logic [REG_ADDR_W-1:0] m_rt;
	logic [DATA_W-1:0]     m_result;
	logic [DATA_W-1:0]     m_store_data;
	logic                  m_fwd;
	logic                  rf_write_en;
	logic [DATA_W-1:0]     rf_write_data;

	// whole core holds while the cache works
	assign advance = run && cache_ready;
	assign im_address = pc;

	instr_decode decode (
		.instruction(if_instr),
		.alu_op(dec_alu_op),
		.use_imm(dec_use_imm),
		.imm_value(dec_imm),
		.reg_write(dec_reg_write),
		.mem_read(dec_mem_read),
		.mem_write(dec_mem_write),
		.is_branch(dec_is_branch),
		.rt(dec_rt),
		.ra(dec_ra),
		.rb(dec_rb)
	);

	regfile rf (
		.clk(clk),
		.reset(reset),
		.ra(dec_ra),
		.rb(dec_rb),
		.ra_data(rf_ra_data),
		.rb_data(rf_rb_data),
		.write_enable(rf_write_en),
		.write_addr(m_rt),
		.write_data(rf_write_data)
	);

	// stage 3 result, load data is valid once the cache lets the stage go
	assign rf_write_data = m_load ? mem_read_data : m_result;
	assign rf_write_en = advance && m_valid && m_reg_write;
	assign m_fwd = m_valid && m_reg_write && (m_rt != '0);

	assign op_a = (m_fwd && m_rt == dec_ra) ? rf_write_data : rf_ra_data;
	assign op_b = (m_fwd && m_rt == dec_rb) ? rf_write_data : rf_rb_data;
	assign alu_src2 = dec_use_imm ? dec_imm : op_b;

	alu alu (
		.alu_op(dec_alu_op),
		.src1(op_a),
		.src2(alu_src2),
		.result(alu_result),
		.overflow(alu_ovf)
	);

	// add, sub and addi update the flag, loads use the adder too
	assign arith_op = dec_reg_write && !dec_mem_read &&
		(dec_alu_op == ALU_ADD || dec_alu_op == ALU_SUB);

	assign branch_taken = if_valid && dec_is_branch && (op_a == op_b);
	assign branch_target = if_pc + dec_imm[9:0];

	assign mem_strobe = run && m_valid && (m_load || m_store);
	assign mem_write = m_store;
	assign mem_address = m_result;
	assign mem_write_data = m_store_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			if_valid <= 1'b0;
			m_valid <= 1'b0;
			alu_overflow <= 1'b0;
		end else if (advance) begin
			if (branch_taken) begin
				// drop the instruction fetched behind the branch
				pc <= branch_target;
				if_valid <= 1'b0;
			end else begin
				pc <= pc + 10'd1;
				if_valid <= 1'b1;
			end
			m_valid <= if_valid;
			if (if_valid && arith_op)
				alu_overflow <= alu_ovf;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			if_instr <= instruction;
			if_pc <= pc;
			m_reg_write <= dec_reg_write;
			m_load <= dec_mem_read;
			m_store <= dec_mem_write;
			m_rt <= dec_rt;
			m_result <= alu_result;
			m_store_data <= op_b;
		end
	end

endmodule

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile import core_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [REG_ADDR_W-1:0] ra,
	input  logic [REG_ADDR_W-1:0] rb,
	output logic [DATA_W-1:0]     ra_data,
	output logic [DATA_W-1:0]     rb_data,
	input  logic                  write_enable,
	input  logic [REG_ADDR_W-1:0] write_addr,
	input  logic [DATA_W-1:0]     write_data
);

	logic [DATA_W-1:0] regs [2**REG_ADDR_W];

	// r0 reads zero, same-cycle write is bypassed
	function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (write_enable && write_addr == addr)
			return write_data;
		return regs[addr];
	endfunction

	always_comb begin
		ra_data = read_port(ra);
		rb_data = read_port(rb);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

endmodule

`default_nettype wire

//--- test/core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module core_assertions import core_pkg::*; (
	input logic              clk,
	input logic              reset,
	input logic              cache_ready,
	input logic              wb_cyc,
	input logic              wb_stb,
	input logic              wb_we,
	input logic [DATA_W-3:0] wb_adr,
	input logic [DATA_W-1:0] wb_dat_write,
	input logic              wb_ack
);

	int failures;

	initial failures = 0;

	// strobe only inside a bus cycle
	assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
	else begin
		failures++;
		$error("wb_stb high while wb_cyc is low");
	end

	// request held until the slave acks
	assert property (@(posedge clk) disable iff (reset)
		(wb_cyc && wb_stb && !wb_ack) |=>
		($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_write)))
	else begin
		failures++;
		$error("wishbone request changed while waiting for wb_ack");
	end

	// core must be stalled for the whole bus cycle
	assert property (@(posedge clk) disable iff (reset) wb_cyc |-> !cache_ready)
	else begin
		failures++;
		$error("cache_ready high during a wishbone cycle");
	end

endmodule

bind dcache core_assertions bus_checks (
	.clk(clk),
	.reset(reset),
	.cache_ready(cache_ready),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_we(wb_we),
	.wb_adr(wb_adr),
	.wb_dat_write(wb_dat_write),
	.wb_ack(wb_ack)
);

`default_nettype wire

//--- test/tb_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core_top import core_pkg::*; ();

	localparam int MARKER_BYTE = 'h0ffc;

	logic        clk;
	logic        reset;
	logic        run;
	logic [9:0]  im_address;
	logic [31:0] instruction;
	logic        alu_overflow;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [29:0] wb_adr;
	logic [31:0] wb_dat_write;
	logic [31:0] wb_dat_read;
	logic        wb_ack;

	logic [31:0] imem [1024];
	logic [31:0] dmem [1024];
	int          prog_len;
	integer      seed;
	logic        in_transfer;
	logic [1:0]  wait_left;
	logic [1:0]  wait_now;
	int          bus_reads;
	int          bus_writes;
	logic        marker_seen;
	logic [29:0] write_adr_log [$];
	logic [31:0] write_dat_log [$];
	logic        write_ovf_log [$];
	int          value_errors;
	int          other_errors;

	core_top #(
		.CACHE_LINES(16)
	) uut (
		.clk(clk),
		.reset(reset),
		.run(run),
		.im_address(im_address),
		.instruction(instruction),
		.alu_overflow(alu_overflow),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_write(wb_dat_write),
		.wb_dat_read(wb_dat_read),
		.wb_ack(wb_ack)
	);

	// instruction memory answers in the same cycle
	assign instruction = imem[im_address];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// wishbone slave with 0 to 3 random wait states per transfer
	always @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			in_transfer <= 1'b0;
			wait_left <= 2'd0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			// a fresh request draws its wait count
			wait_now = in_transfer ? wait_left : 2'($random(seed));
			if (wait_now != 2'd0) begin
				in_transfer <= 1'b1;
				wait_left <= wait_now - 2'd1;
			end else begin
				in_transfer <= 1'b0;
				wb_ack <= 1'b1;
				if (wb_we) begin
					dmem[wb_adr[9:0]] <= wb_dat_write;
					bus_writes <= bus_writes + 1;
					write_adr_log.push_back(wb_adr);
					write_dat_log.push_back(wb_dat_write);
					// flag as seen while the store waits on the bus
					write_ovf_log.push_back(alu_overflow);
					if (wb_adr == 30'(MARKER_BYTE >> 2))
						marker_seen <= 1'b1;
				end else begin
					wb_dat_read <= dmem[wb_adr[9:0]];
					bus_reads <= bus_reads + 1;
				end
			end
		end
	end

	function automatic logic [31:0] reg_word(input logic [4:0] sub_op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb);
		instr_u w;
		w = '0;
		w.rtype.opcode = OP_ALU;
		w.rtype.rt = rt;
		w.rtype.ra = ra;
		w.rtype.rb = rb;
		w.rtype.sub_op = sub_op;
		return w;
	endfunction

	function automatic logic [31:0] imm_word(input logic [5:0] opcode, input logic [4:0] rt,
			input logic [4:0] ra, input logic [14:0] imm);
		instr_u w;
		w = '0;
		w.itype.opcode = opcode;
		w.itype.rt = rt;
		w.itype.ra = ra;
		w.itype.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] fill_word(input int index);
		return 32'ha5000000 ^ (index * 32'h00010001);
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	task automatic new_program();
		for (int i = 0; i < 1024; i++) begin
			imem[i] = '0;
			dmem[i] = fill_word(i);
		end
		prog_len = 0;
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else begin
			value_errors++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1)
		else begin
			other_errors++;
			$display("at %0t: %s", $time, what);
		end
	endtask

	task automatic check_mem(input int byte_addr, input logic [31:0] expected);
		check_word($sformatf("mem[0x%03h]", byte_addr), expected, dmem[byte_addr >> 2]);
	endtask

	// append the marker store then reset and run until it lands
	task automatic run_program(input string name);
		int cycles;
		emit(imm_word(OP_SWI, 0, 0, MARKER_BYTE));
		write_adr_log.delete();
		write_dat_log.delete();
		write_ovf_log.delete();
		bus_reads = 0;
		bus_writes = 0;
		marker_seen = 1'b0;
		@(posedge clk);
		reset <= 1'b1;
		run <= 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		run <= 1'b1;
		cycles = 0;
		while (!marker_seen && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		run <= 1'b0;
		check_true(marker_seen, {name, ": timed out waiting for the end-of-program store"});
	endtask

	task automatic test_alu();
		logic [31:0] expected [1:8];
		new_program();
		expected[1] = 32'd1234;
		expected[2] = 32'h00007abc;
		expected[3] = 32'hfffffffb;
		expected[4] = expected[1] + expected[3];
		expected[5] = expected[1] - expected[2];
		expected[6] = expected[2] & expected[3];
		expected[7] = expected[1] | expected[3];
		expected[8] = expected[2] ^ expected[3];
		emit(imm_word(OP_ADDI, 1, 0, 1234));
		emit(imm_word(OP_ORI, 2, 0, 'h7abc));
		emit(imm_word(OP_ADDI, 3, 0, -5));
		emit(reg_word(SUB_ADD, 4, 1, 3));
		emit(reg_word(SUB_SUB, 5, 1, 2));
		emit(reg_word(SUB_AND, 6, 2, 3));
		emit(reg_word(SUB_OR, 7, 1, 3));
		emit(reg_word(SUB_XOR, 8, 2, 3));
		for (int r = 1; r <= 8; r++)
			emit(imm_word(OP_SWI, r, 0, 'h100 + 4 * r));
		run_program("alu");
		for (int r = 1; r <= 8; r++)
			check_mem('h100 + 4 * r, expected[r]);
	endtask

	task automatic test_forwarding();
		new_program();
		emit(imm_word(OP_ADDI, 1, 0, 7));
		emit(reg_word(SUB_ADD, 2, 1, 1));
		emit(reg_word(SUB_ADD, 3, 2, 1));
		emit(imm_word(OP_SWI, 3, 0, 'h180));
		// load result used by the very next instruction
		emit(imm_word(OP_LWI, 4, 0, 'h180));
		emit(reg_word(SUB_ADD, 5, 4, 4));
		emit(imm_word(OP_LWI, 6, 0, 'h248));
		emit(reg_word(SUB_SUB, 7, 6, 1));
		emit(imm_word(OP_SWI, 5, 0, 'h184));
		emit(imm_word(OP_SWI, 7, 0, 'h188));
		emit(imm_word(OP_SWI, 2, 0, 'h18c));
		run_program("forwarding");
		check_mem('h180, 21);
		check_mem('h184, 42);
		check_mem('h188, fill_word('h248 >> 2) - 7);
		check_mem('h18c, 14);
	endtask

	task automatic test_cache();
		new_program();
		emit(imm_word(OP_ADDI, 1, 0, 99));
		emit(imm_word(OP_SWI, 1, 0, 'h040));
		emit(imm_word(OP_LWI, 2, 0, 'h040));
		emit(imm_word(OP_SWI, 2, 0, 'h044));
		// untouched word where the second load hits
		emit(imm_word(OP_LWI, 3, 0, 'h208));
		emit(imm_word(OP_LWI, 4, 0, 'h208));
		emit(reg_word(SUB_ADD, 5, 3, 4));
		emit(imm_word(OP_SWI, 5, 0, 'h050));
		run_program("cache");
		check_mem('h044, 99);
		check_mem('h050, fill_word('h208 >> 2) * 2);
		check_word("bus reads", 1, bus_reads);
		check_word("bus writes", 4, bus_writes);
	endtask

	task automatic test_backpressure();
		new_program();
		for (int k = 1; k <= 8; k++)
			emit(imm_word(OP_ADDI, k, 0, 300 + 37 * k));
		for (int k = 1; k <= 8; k++)
			emit(imm_word(OP_SWI, k, 0, 'h300 + 4 * k));
		run_program("backpressure");
		check_word("bus write count", 9, write_adr_log.size());
		for (int k = 1; k <= 8 && k <= write_adr_log.size(); k++) begin
			check_word($sformatf("wb_adr of store %0d", k), ('h300 + 4 * k) >> 2,
				write_adr_log[k - 1]);
			check_word($sformatf("wb_dat_write of store %0d", k), 300 + 37 * k,
				write_dat_log[k - 1]);
		end
	endtask

	task automatic test_branch();
		new_program();
		emit(imm_word(OP_ADDI, 1, 0, 5));
		emit(imm_word(OP_ADDI, 2, 0, 5));
		emit(imm_word(OP_BEQ, 1, 2, 2));
		emit(imm_word(OP_SWI, 1, 0, 'h3c0));
		emit(imm_word(OP_ADDI, 3, 0, 6));
		emit(imm_word(OP_BEQ, 3, 1, 2));
		emit(imm_word(OP_SWI, 3, 0, 'h3c4));
		run_program("branch");
		foreach (write_adr_log[i])
			check_true(write_adr_log[i] != ('h3c0 >> 2),
				"store behind a taken BEQ reached the bus");
		check_word("bus writes", 2, bus_writes);
		check_mem('h3c0, fill_word('h3c0 >> 2));
		check_mem('h3c4, 6);
	endtask

	task automatic test_overflow();
		new_program();
		dmem['h3e0 >> 2] = 32'h7fffffff;
		emit(imm_word(OP_LWI, 1, 0, 'h3e0));
		emit(imm_word(OP_ADDI, 2, 0, 1));
		emit(reg_word(SUB_ADD, 3, 1, 2));
		emit(imm_word(OP_SWI, 3, 0, 'h3e4));
		emit(reg_word(SUB_ADD, 4, 2, 2));
		emit(imm_word(OP_SWI, 4, 0, 'h3e8));
		run_program("overflow");
		check_word("bus write count", 3, write_adr_log.size());
		if (write_adr_log.size() >= 2) begin
			check_word("wb_dat_write after overflow", 32'h80000000, write_dat_log[0]);
			check_word("alu_overflow after overflow", 1, write_ovf_log[0]);
			check_word("wb_dat_write after plain add", 2, write_dat_log[1]);
			check_word("alu_overflow after plain add", 0, write_ovf_log[1]);
		end
		check_word("alu_overflow at end", 0, alu_overflow);
	endtask

	initial begin
		seed = 87;
		reset = 1'b1;
		run = 1'b0;
		wb_ack = 1'b0;
		wb_dat_read = '0;
		value_errors = 0;
		other_errors = 0;
		test_alu();
		test_forwarding();
		test_cache();
		test_backpressure();
		test_branch();
		test_overflow();
		$display("errors: %0d wrong values, %0d other failures, %0d bus assertion failures",
			value_errors, other_errors, uut.dcache.bus_checks.failures);
		if (value_errors == 0 && other_errors == 0 && uut.dcache.bus_checks.failures == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
